/* all.f */
verilog/game_pkg.sv
verilog/draw_pkg.sv
verilog/round_timer.sv
verilog/target_picker.sv
verilog/answer_judge.sv
verilog/square_plotter.sv
verilog/round_fsm.sv
verilog/clicky_top.sv
dv/clicky_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module clicky_tb -f all.f -o clicky_sim
	./obj_dir/clicky_sim | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/clicky_tb.sv */
`timescale 1ns/1ps

module clicky_tb import game_pkg::*, draw_pkg::*;
();

   localparam int unsigned ROUND_TICKS = 3000;
   localparam int unsigned SPEED_STEP  = 400;
   localparam int unsigned MIN_TICKS   = 1000;
   localparam int          NUM_ROUNDS  = 150;
   localparam int          DRAW_LIMIT  = ROUND_TICKS + 3000;
   localparam int          WATCHDOG_CYCLES = NUM_ROUNDS * (ROUND_TICKS + 2000) + 20000;

   typedef struct packed
   {
      score_t      score;
      lives_t      lives;
      logic [31:0] ticks;
   } expect_t;

   logic          clk;
   logic          reset;
   logic [3:0]    keys;
   logic          restart;
   logic          plot;
   coord_t        x;
   coord_t        y;
   pixel_colour_t colour;
   score_t        score;
   score_t        high_score;
   lives_t        lives;

   // Scoreboard
   int            checks_done  = 0;
   int            mismatches   = 0;
   int            other_errors = 0;
   score_t        exp_score;
   score_t        exp_high;
   lives_t        exp_lives;
   logic [31:0]   exp_ticks;
   logic [31:0]   ticks_prev;

   // Monitor state
   logic [31:0]   cycle;
   int            pix_idx;
   logic          round_drawn;
   logic          no_plot;
   logic          fresh_game;
   logic [31:0]   last_start;
   logic [31:0]   gap_measured;
   logic          gap_ready;
   int            overhead;
   square_t       seen_square;
   colour_class_t seen_class;
   pixel_colour_t seen_colour;
   int            elapsed;
   logic          abort;
   event          compare_ev;

   clicky_top
   #(
      .ROUND_TICKS (ROUND_TICKS),
      .SPEED_STEP  (SPEED_STEP),
      .MIN_TICKS   (MIN_TICKS)
   )
   clicky_top_inst
   (
      .clk        (clk),
      .reset      (reset),
      .keys       (keys),
      .restart    (restart),
      .plot       (plot),
      .x          (x),
      .y          (y),
      .colour     (colour),
      .score      (score),
      .high_score (high_score),
      .lives      (lives)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   always @(posedge clk)
      cycle <= reset ? 32'd0 : cycle + 32'd1;

   // **************************************************************************
   // Checking helpers
   // **************************************************************************
   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks_done++;
      assert (actual === expected)
      else
      begin
         $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
         mismatches++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      checks_done++;
      assert (cond === 1'b1)
      else
      begin
         $display("%s", what);
         other_errors++;
      end
   endtask

   task automatic finish_run();
      $display("Checks %0d, mismatches %0d, other errors %0d",
               checks_done, mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   endtask

   // Expected outcome of one round from the colour rules
   function automatic expect_t predict_round(input colour_class_t cls, input square_t target,
                                             input int pressed, input expect_t cur);
      expect_t nxt;
      logic    hit;
      logic    lose;
      nxt  = cur;
      hit  = (pressed == int'(target));
      lose = 1'b0;
      if (pressed < 0)
         lose = (cls == CLASS_RED) || (cls == CLASS_YELLOW);
      else
      begin
         case (cls)
            CLASS_RED:
               if (hit)
                  nxt.score = cur.score + 16'd1;
               else
                  lose = 1'b1;
            CLASS_YELLOW:
               if (hit)
                  lose = 1'b1;
               else
                  nxt.score = cur.score + 16'd1;
            CLASS_GREEN:
               if (hit && cur.lives != LIVES_MAX)
                  nxt.lives = cur.lives + 4'd1;
            CLASS_PINK:
               if (hit)
                  nxt.ticks = (cur.ticks >= MIN_TICKS + SPEED_STEP) ?
                              cur.ticks - SPEED_STEP : MIN_TICKS;
            default:
               if (hit)
                  nxt.ticks = (cur.ticks + SPEED_STEP <= ROUND_TICKS) ?
                              cur.ticks + SPEED_STEP : ROUND_TICKS;
         endcase
      end
      if (lose && nxt.lives != 4'd0)
         nxt.lives = nxt.lives - 4'd1;
      return nxt;
   endfunction

   // **************************************************************************
   // Pixel monitor
   // **************************************************************************
   task automatic decode_target();
      logic found;
      found = 1'b0;
      for (int i = 0; i < 4; i++)
      begin
         if (x == SQUARE_X[i])
         begin
            seen_square = square_t'(i);
            found       = 1'b1;
         end
      end
      check_true(found, "Coloured square starts at an unknown x position");
      seen_colour = colour;
      case (colour)
         PIX_RED:    seen_class = CLASS_RED;
         PIX_YELLOW: seen_class = CLASS_YELLOW;
         PIX_GREEN:  seen_class = CLASS_GREEN;
         PIX_PINK:   seen_class = CLASS_PINK;
         PIX_CYAN:   seen_class = CLASS_CYAN;
         default:
         begin
            check_true(1'b0, "Coloured square has no class colour");
            seen_class = CLASS_RED;
         end
      endcase
   endtask

   task automatic note_round_start();
      if (fresh_game)
         fresh_game = 1'b0;
      else
      begin
         gap_measured = cycle - last_start;
         gap_ready    = 1'b1;
      end
      last_start = cycle;
      -> compare_ev;
   endtask

   always @(negedge clk)
   begin
      int            sprite;
      int            k;
      coord_t        want_x;
      coord_t        want_y;
      pixel_colour_t want_colour;
      if (reset)
         pix_idx = 0;
      else if (plot)
      begin
         check_true(!no_plot, "Pixel plotted while the game is over");
         sprite = pix_idx / SPRITE_PIXELS;
         k      = pix_idx % SPRITE_PIXELS;
         if (pix_idx == 0)
            note_round_start();
         if (sprite == 4 && k == 0)
            decode_target();
         if (sprite < 4)
         begin
            want_x      = SQUARE_X[sprite];
            want_colour = PIX_WHITE;
         end
         else
         begin
            want_x      = SQUARE_X[seen_square];
            want_colour = seen_colour;
         end
         want_x = want_x + coord_t'(k % SPRITE_SIDE);
         want_y = SQUARE_Y + coord_t'(k / SPRITE_SIDE);
         check_value("x", 32'(x), 32'(want_x));
         check_value("y", 32'(y), 32'(want_y));
         check_value("colour", 32'(colour), 32'(want_colour));
         pix_idx++;
         if (pix_idx == 5 * SPRITE_PIXELS)
         begin
            pix_idx     = 0;
            round_drawn = 1'b1;
         end
      end
   end

   // Outputs against the expected game state
   always
   begin
      @(compare_ev);
      check_value("score", 32'(score), 32'(exp_score));
      check_value("high_score", 32'(high_score), 32'(exp_high));
      check_value("lives", 32'(lives), 32'(exp_lives));
      if (gap_ready)
      begin
         // First full round gives the fixed drawing and update overhead
         if (overhead < 0)
         begin
            overhead = int'(gap_measured - ticks_prev);
            check_true(overhead > 5 * SPRITE_PIXELS, "Round overhead shorter than drawing");
         end
         else
            check_value("round gap", gap_measured, ticks_prev + overhead);
      end
      gap_ready = 1'b0;
   end

   // **************************************************************************
   // Stimulus
   // **************************************************************************
   task automatic advance(input int n);
      repeat (n) @(posedge clk);
      #1;
      elapsed += n;
   endtask

   task automatic press_key(input int key);
      keys = 4'b0001 << key;
      advance(1 + $urandom % 30);
      keys = 4'b0000;
      advance(1);
   endtask

   task automatic wait_round_drawn();
      int waited;
      waited = 0;
      while (!round_drawn && waited < DRAW_LIMIT)
      begin
         advance(1);
         waited++;
      end
      check_true(round_drawn, "No complete round was drawn within the time limit");
      if (!round_drawn)
         abort = 1'b1;
      round_drawn = 1'b0;
   endtask

   task automatic game_over_and_restart();
      no_plot = 1'b1;
      // Past the end of the round, then hold off before restart
      advance(int'(ticks_prev) + 100 - elapsed);
      -> compare_ev;
      advance(1 + $urandom % 40);
      restart = 1'b1;
      advance(1 + $urandom % 8);
      restart    = 1'b0;
      no_plot    = 1'b0;
      fresh_game = 1'b1;
      exp_score  = '0;
      exp_lives  = LIVES_START;
      exp_ticks  = ROUND_TICKS;
   endtask

   task automatic play_round();
      int      choice;
      int      key;
      int      first_key;
      expect_t cur;
      expect_t nxt;
      wait_round_drawn();
      if (abort)
         return;
      elapsed    = 0;
      ticks_prev = exp_ticks;
      first_key  = -1;
      choice     = $urandom % 8;
      if (choice >= 2)
      begin
         if (choice < 6)
            key = int'(seen_square);
         else
            key = $urandom % 4;
         advance(1 + $urandom % (ticks_prev / 2));
         press_key(key);
         first_key = key;
         // Second press must not change the outcome
         if ($urandom % 2)
         begin
            advance(1 + $urandom % 20);
            press_key($urandom % 4);
         end
      end
      cur.score = exp_score;
      cur.lives = exp_lives;
      cur.ticks = exp_ticks;
      nxt       = predict_round(seen_class, seen_square, first_key, cur);
      exp_score = nxt.score;
      exp_lives = nxt.lives;
      exp_ticks = nxt.ticks;
      if (nxt.score > exp_high)
         exp_high = nxt.score;
      if (nxt.lives == 4'd0)
         game_over_and_restart();
   endtask

   initial
   begin
      void'($urandom(32'hc739));
      reset        = 1'b1;
      keys         = 4'b0000;
      restart      = 1'b0;
      round_drawn  = 1'b0;
      no_plot      = 1'b0;
      fresh_game   = 1'b1;
      last_start   = '0;
      gap_measured = '0;
      gap_ready    = 1'b0;
      overhead     = -1;
      seen_square  = '0;
      seen_class   = CLASS_RED;
      seen_colour  = PIX_BLACK;
      elapsed      = 0;
      abort        = 1'b0;
      exp_score    = '0;
      exp_high     = '0;
      exp_lives    = LIVES_START;
      exp_ticks    = ROUND_TICKS;
      ticks_prev   = ROUND_TICKS;
      repeat (4) @(posedge clk);
      #1 reset = 1'b0;
      for (int r = 0; r < NUM_ROUNDS && !abort; r++)
         play_round();
      // Next round start compares the last round
      if (!abort)
         wait_round_drawn();
      finish_run();
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired before all rounds were played");
      other_errors++;
      finish_run();
   end

endmodule

/* verilog/clicky_top.sv */
`timescale 1ns/1ps

module clicky_top import game_pkg::*, draw_pkg::*;
#(
   parameter int unsigned ROUND_TICKS = 180_000_000,
   parameter int unsigned SPEED_STEP  = 10_000_000,
   parameter int unsigned MIN_TICKS   = 20_000_000,
   parameter int          TICK_WIDTH  = 31
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic [3:0]    keys,
   input  logic          restart,
   output logic          plot,
   output coord_t        x,
   output coord_t        y,
   output pixel_colour_t colour,
   output score_t        score,
   output score_t        high_score,
   output lives_t        lives
);

   logic                  load_white;
   square_t               white_index;
   logic                  load_target;
   logic                  draw_enable;
   logic                  sprite_done;
   logic                  timer_start;
   logic                  times_up;
   logic                  new_game;
   logic                  new_round;
   logic                  press;
   square_t               press_square;
   logic                  apply_update;
   square_t               target_square;
   colour_class_t         target_class;
   pixel_colour_t         target_colour;
   logic [TICK_WIDTH-1:0] round_ticks;

   // **************************************************************************
   // Control
   // **************************************************************************
   round_fsm round_fsm_inst
   (
      .clk          (clk),
      .reset        (reset),
      .keys         (keys),
      .restart      (restart),
      .sprite_done  (sprite_done),
      .times_up     (times_up),
      .lives        (lives),
      .load_white   (load_white),
      .white_index  (white_index),
      .load_target  (load_target),
      .draw_enable  (draw_enable),
      .timer_start  (timer_start),
      .new_game     (new_game),
      .new_round    (new_round),
      .press        (press),
      .press_square (press_square),
      .apply_update (apply_update)
   );

   round_timer #(.TICK_WIDTH(TICK_WIDTH)) round_timer_inst
   (
      .clk         (clk),
      .reset       (reset),
      .timer_start (timer_start),
      .round_ticks (round_ticks),
      .times_up    (times_up)
   );

   // **************************************************************************
   // Game state and drawing
   // **************************************************************************
   target_picker target_picker_inst
   (
      .clk           (clk),
      .reset         (reset),
      .load_target   (load_target),
      .target_square (target_square),
      .target_class  (target_class),
      .target_colour (target_colour)
   );

   answer_judge
   #(
      .ROUND_TICKS (ROUND_TICKS),
      .SPEED_STEP  (SPEED_STEP),
      .MIN_TICKS   (MIN_TICKS),
      .TICK_WIDTH  (TICK_WIDTH)
   )
   answer_judge_inst
   (
      .clk           (clk),
      .reset         (reset),
      .new_game      (new_game),
      .new_round     (new_round),
      .press         (press),
      .press_square  (press_square),
      .apply_update  (apply_update),
      .target_square (target_square),
      .target_class  (target_class),
      .score         (score),
      .high_score    (high_score),
      .lives         (lives),
      .round_ticks   (round_ticks)
   );

   square_plotter square_plotter_inst
   (
      .clk           (clk),
      .reset         (reset),
      .load_white    (load_white),
      .white_index   (white_index),
      .load_target   (load_target),
      .target_square (target_square),
      .target_colour (target_colour),
      .draw_enable   (draw_enable),
      .plot          (plot),
      .x             (x),
      .y             (y),
      .colour        (colour),
      .sprite_done   (sprite_done)
   );

endmodule

/* verilog/round_fsm.sv */
`timescale 1ns/1ps

module round_fsm import game_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic [3:0] keys,
   input  logic       restart,
   input  logic       sprite_done,
   input  logic       times_up,
   input  lives_t     lives,
   output logic       load_white,
   output square_t    white_index,
   output logic       load_target,
   output logic       draw_enable,
   output logic       timer_start,
   output logic       new_game,
   output logic       new_round,
   output logic       press,
   output square_t    press_square,
   output logic       apply_update
);

   typedef enum logic [3:0]
   {
      S_NEW_GAME,
      S_LOAD_WHITE,
      S_DRAW_WHITE,
      S_LOAD_TARGET,
      S_DRAW_TARGET,
      S_ANSWER,
      S_KEY_HELD,
      S_TIME_UP,
      S_SETTLE,
      S_GAME_OVER,
      S_RESTART_WAIT
   } state_t;

   state_t  state;
   state_t  state_next;
   square_t held_square;

   // Lowest numbered key wins
   always_comb
   begin
      press_square = '0;
      for (int i = 3; i >= 0; i--)
         if (keys[i])
            press_square = square_t'(i);
   end

   always_comb
   begin
      state_next = state;
      case (state)
         S_NEW_GAME:    state_next = S_LOAD_WHITE;
         S_LOAD_WHITE:  state_next = S_DRAW_WHITE;
         S_DRAW_WHITE:
            if (sprite_done)
               state_next = (white_index == 2'd3) ? S_LOAD_TARGET : S_LOAD_WHITE;
         S_LOAD_TARGET: state_next = S_DRAW_TARGET;
         S_DRAW_TARGET:
            if (sprite_done)
               state_next = S_ANSWER;
         S_ANSWER:
            if (times_up)
               state_next = S_TIME_UP;
            else if (|keys)
               state_next = S_KEY_HELD;
         // Timer keeps running while the key is down
         S_KEY_HELD:
            if (times_up)
               state_next = S_TIME_UP;
            else if (!keys[held_square])
               state_next = S_ANSWER;
         S_TIME_UP:     state_next = S_SETTLE;
         S_SETTLE:      state_next = (lives == '0) ? S_GAME_OVER : S_LOAD_WHITE;
         S_GAME_OVER:
            if (restart)
               state_next = S_RESTART_WAIT;
         S_RESTART_WAIT:
            if (!restart)
               state_next = S_NEW_GAME;
         default:       state_next = S_NEW_GAME;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state       <= S_NEW_GAME;
         white_index <= '0;
      end
      else
      begin
         state <= state_next;
         // Wraps back to 0 after the fourth white square
         if (state == S_DRAW_WHITE && sprite_done)
            white_index <= white_index + 2'd1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         held_square <= '0;
      else if (press)
         held_square <= press_square;
   end

   assign load_white   = (state == S_LOAD_WHITE);
   assign load_target  = (state == S_LOAD_TARGET);
   assign draw_enable  = (state == S_DRAW_WHITE) || (state == S_DRAW_TARGET);
   assign timer_start  = (state == S_DRAW_TARGET) && sprite_done;
   assign new_game     = (state == S_NEW_GAME);
   assign new_round    = (state == S_LOAD_TARGET);
   assign press        = (state == S_ANSWER) && !times_up && (|keys);
   assign apply_update = (state == S_TIME_UP);

endmodule

/* verilog/square_plotter.sv */
`timescale 1ns/1ps

module square_plotter import game_pkg::*, draw_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          load_white,
   input  square_t       white_index,
   input  logic          load_target,
   input  square_t       target_square,
   input  pixel_colour_t target_colour,
   input  logic          draw_enable,
   output logic          plot,
   output coord_t        x,
   output coord_t        y,
   output pixel_colour_t colour,
   output logic          sprite_done
);

   localparam int SIDE_BITS = $clog2(SPRITE_SIDE);
   localparam int CNT_BITS  = $clog2(SPRITE_PIXELS);

   logic [CNT_BITS-1:0] pix_cnt;
   square_t             white_square;
   logic                is_target;
   square_t             base_square;
   coord_t              base_x;
   pixel_colour_t       base_colour;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pix_cnt      <= '0;
         white_square <= '0;
         is_target    <= 1'b0;
      end
      else
      begin
         if (load_white)
         begin
            white_square <= white_index;
            is_target    <= 1'b0;
         end
         else if (load_target)
            is_target <= 1'b1;

         if (load_white || load_target)
            pix_cnt <= '0;
         else if (draw_enable)
            pix_cnt <= pix_cnt + 1'b1;
      end
   end

   // Picker latches on the same load, then holds steady through the draw
   assign base_square = is_target ? target_square : white_square;
   assign base_x      = SQUARE_X[base_square];
   assign base_colour = is_target ? target_colour : PIX_WHITE;
   assign sprite_done = draw_enable && (pix_cnt == CNT_BITS'(SPRITE_PIXELS - 1));

   // **************************************************************************
   // Pixel write one cycle behind the count
   // **************************************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
         plot <= 1'b0;
      else
         plot <= draw_enable;
   end

   always_ff @(posedge clk)
   begin
      x      <= base_x + coord_t'(pix_cnt[SIDE_BITS-1:0]);
      y      <= SQUARE_Y + coord_t'(pix_cnt[CNT_BITS-1:SIDE_BITS]);
      colour <= base_colour;
   end

endmodule

/* verilog/answer_judge.sv */
`timescale 1ns/1ps

module answer_judge import game_pkg::*;
#(
   parameter int unsigned ROUND_TICKS = 180_000_000,
   parameter int unsigned SPEED_STEP  = 10_000_000,
   parameter int unsigned MIN_TICKS   = 20_000_000,
   parameter int          TICK_WIDTH  = 31
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  new_game,
   input  logic                  new_round,
   input  logic                  press,
   input  square_t               press_square,
   input  logic                  apply_update,
   input  square_t               target_square,
   input  colour_class_t         target_class,
   output score_t                score,
   output score_t                high_score,
   output lives_t                lives,
   output logic [TICK_WIDTH-1:0] round_ticks
);

   localparam logic [TICK_WIDTH-1:0] TICKS_MAX  = TICK_WIDTH'(ROUND_TICKS);
   localparam logic [TICK_WIDTH-1:0] TICKS_MIN  = TICK_WIDTH'(MIN_TICKS);
   localparam logic [TICK_WIDTH-1:0] TICKS_STEP = TICK_WIDTH'(SPEED_STEP);

   logic   answered;
   logic   hit;
   logic   pend_score;
   logic   pend_lose;
   logic   pend_gain;
   logic   pend_faster;
   logic   pend_slower;
   logic   timeout_loss;
   score_t score_inc;

   assign hit          = (press_square == target_square);
   assign score_inc    = score + 16'd1;
   assign timeout_loss = !answered &&
                         (target_class == CLASS_RED || target_class == CLASS_YELLOW);

   // **************************************************************************
   // Pending effect from the first press
   // **************************************************************************
   always_ff @(posedge clk)
   begin
      if (reset || new_round)
      begin
         answered    <= 1'b0;
         pend_score  <= 1'b0;
         pend_lose   <= 1'b0;
         pend_gain   <= 1'b0;
         pend_faster <= 1'b0;
         pend_slower <= 1'b0;
      end
      else if (press && !answered)
      begin
         answered <= 1'b1;
         case (target_class)
            CLASS_RED:
            begin
               pend_score <= hit;
               pend_lose  <= !hit;
            end
            // Yellow means press anything else
            CLASS_YELLOW:
            begin
               pend_score <= !hit;
               pend_lose  <= hit;
            end
            CLASS_GREEN: pend_gain   <= hit;
            CLASS_PINK:  pend_faster <= hit;
            default:     pend_slower <= hit;
         endcase
      end
   end

   // **************************************************************************
   // Round end update
   // **************************************************************************
   always_ff @(posedge clk)
   begin
      if (reset || new_game)
      begin
         score       <= '0;
         lives       <= LIVES_START;
         round_ticks <= TICKS_MAX;
      end
      else if (apply_update)
      begin
         if (pend_score)
            score <= score_inc;
         if ((pend_lose || timeout_loss) && lives != '0)
            lives <= lives - 4'd1;
         if (pend_gain && lives != LIVES_MAX)
            lives <= lives + 4'd1;
         // Period clamped between floor and default
         if (pend_faster)
            round_ticks <= (round_ticks < TICKS_MIN + TICKS_STEP) ?
                           TICKS_MIN : round_ticks - TICKS_STEP;
         if (pend_slower)
            round_ticks <= (round_ticks > TICKS_MAX - TICKS_STEP) ?
                           TICKS_MAX : round_ticks + TICKS_STEP;
      end
   end

   // Survives new games
   always_ff @(posedge clk)
   begin
      if (reset)
         high_score <= '0;
      else if (apply_update && pend_score && score_inc > high_score)
         high_score <= score_inc;
   end

endmodule

/* verilog/target_picker.sv */
`timescale 1ns/1ps

module target_picker import game_pkg::*, draw_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  logic          load_target,
   output square_t       target_square,
   output colour_class_t target_class,
   output pixel_colour_t target_colour
);

   square_t                     square_cnt;
   logic [COLOUR_DRAW_BITS-1:0] colour_cnt;
   colour_class_t               drawn_class;

   // **************************************************************************
   // Free running selectors
   // **************************************************************************
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         square_cnt <= '0;
         colour_cnt <= '0;
      end
      else
      begin
         square_cnt <= square_cnt + 2'd1;
         if (colour_cnt == COLOUR_DRAW_MAX)
            colour_cnt <= '0;
         else
            colour_cnt <= colour_cnt + 1'b1;
      end
   end

   // Map selector value to a class through the bands
   always_comb
   begin
      if (colour_cnt <= RED_TOP)
         drawn_class = CLASS_RED;
      else if (colour_cnt <= YELLOW_TOP)
         drawn_class = CLASS_YELLOW;
      else if (colour_cnt <= GREEN_TOP)
         drawn_class = CLASS_GREEN;
      else if (colour_cnt <= PINK_TOP)
         drawn_class = CLASS_PINK;
      else
         drawn_class = CLASS_CYAN;
   end

   // Held for the whole round
   always_ff @(posedge clk)
   begin
      if (load_target)
      begin
         target_square <= square_cnt;
         target_class  <= drawn_class;
      end
   end

   always_comb
   begin
      case (target_class)
         CLASS_RED:    target_colour = PIX_RED;
         CLASS_YELLOW: target_colour = PIX_YELLOW;
         CLASS_GREEN:  target_colour = PIX_GREEN;
         CLASS_PINK:   target_colour = PIX_PINK;
         default:      target_colour = PIX_CYAN;
      endcase
   end

endmodule

/* verilog/round_timer.sv */
`timescale 1ns/1ps

module round_timer
#(
   parameter int TICK_WIDTH = 31
)
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  timer_start,
   input  logic [TICK_WIDTH-1:0] round_ticks,
   output logic                  times_up
);

   logic [TICK_WIDTH-1:0] count;

   // Count of zero means idle
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count    <= '0;
         times_up <= 1'b0;
      end
      else
      begin
         times_up <= 1'b0;
         if (timer_start)
            count <= round_ticks - 1'b1;
         else if (count != '0)
         begin
            count    <= count - 1'b1;
            // Pulse lands round_ticks cycles after the start
            times_up <= (count == 1);
         end
      end
   end

endmodule

/* verilog/draw_pkg.sv */
package draw_pkg;

   // Screen is 160x120, so one byte covers either axis
   typedef logic [7:0] coord_t;

   // One bit each of red, green and blue
   typedef logic [2:0] pixel_colour_t;

   localparam pixel_colour_t PIX_BLACK  = 3'b000;
   localparam pixel_colour_t PIX_GREEN  = 3'b010;
   localparam pixel_colour_t PIX_CYAN   = 3'b011;
   localparam pixel_colour_t PIX_RED    = 3'b100;
   localparam pixel_colour_t PIX_PINK   = 3'b101;
   localparam pixel_colour_t PIX_YELLOW = 3'b110;
   localparam pixel_colour_t PIX_WHITE  = 3'b111;

   // **************************************************************************
   // Sprite geometry
   // **************************************************************************
   localparam int SPRITE_SIDE   = 16;
   localparam int SPRITE_PIXELS = SPRITE_SIDE * SPRITE_SIDE;

   // Left edge of each square on the shared row
   localparam coord_t SQUARE_X [4] = '{8'd30, 8'd60, 8'd90, 8'd120};
   localparam coord_t SQUARE_Y     = 8'd52;

endpackage

/* verilog/game_pkg.sv */
package game_pkg;

   // Square position counted from the left
   typedef logic [1:0] square_t;

   // What the coloured square asks of the player
   typedef enum logic [2:0]
   {
      CLASS_RED,
      CLASS_YELLOW,
      CLASS_GREEN,
      CLASS_PINK,
      CLASS_CYAN
   } colour_class_t;

   typedef logic [15:0] score_t;
   typedef logic [3:0]  lives_t;

   localparam lives_t LIVES_START = 4'd3;
   localparam lives_t LIVES_MAX   = 4'd15;

   // **************************************************************************
   // Colour selector bands
   // **************************************************************************
   localparam int COLOUR_DRAW_BITS = 7;

   // Inclusive upper bound of each band
   localparam logic [COLOUR_DRAW_BITS-1:0] COLOUR_DRAW_MAX = 7'd100;
   localparam logic [COLOUR_DRAW_BITS-1:0] RED_TOP         = 7'd44;
   localparam logic [COLOUR_DRAW_BITS-1:0] YELLOW_TOP      = 7'd89;
   localparam logic [COLOUR_DRAW_BITS-1:0] GREEN_TOP       = 7'd94;
   localparam logic [COLOUR_DRAW_BITS-1:0] PINK_TOP        = 7'd97;

endpackage
